/* Makefile */
# Verilator build and run for the TCB subsystem testbench

VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal --timescale 1ns/100ps
TOP       := tcb_tb
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass only when the simulation prints the pass line
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^TEST PASSED$$'

clean:
	rm -rf $(OBJ_DIR)

/* bench/tcb_checker.sv */
/* reference model of the TCB subsystem, byte memory,
   response queue, comparison and error counting */

`default_nettype none

`include "tcb_consts.svh"

module tcb_checker (
  input  logic              clk,
  input  logic              reset,
  // request lines as driven to the DUT
  input  logic              vld,
  input  logic              wen,
  input  tcb_pkg::tcb_adr_t adr,
  input  tcb_pkg::tcb_siz_t siz,
  input  tcb_pkg::tcb_ndn_t ndn,
  input  tcb_pkg::tcb_dat_t wdt,
  // DUT outputs
  input  logic              rdy,
  input  logic              rsp_vld,
  input  tcb_pkg::tcb_dat_t rdt,
  input  logic              err,
  // totals for the closing line
  output int                chk_cnt,
  output int                err_cnt
);

  timeunit 1ns;
  timeprecision 100ps;

  // byte addressed model, zero as after the clear
  logic [7:0] model [2**`TCB_ABW];

  // expected responses, one per accepted request
  tcb_pkg::tcb_dat_t exp_rdt_q [$];
  logic              exp_err_q [$];

  // rising edges since reset went low
  int run_cnt;

  initial begin
    chk_cnt = 0;
    err_cnt = 0;
    foreach (model[i]) model[i] = 8'h00;
  end

  always @(posedge clk) begin
    if (reset) run_cnt <= 0;
    else run_cnt <= run_cnt + 1;
  end

  //////////////////////////////////////////////////
  // model and compare
  //////////////////////////////////////////////////

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("FAIL %0d ns %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  // legal when size fits the bus and address is a multiple of it
  task automatic predict(output logic [31:0] exp_rdt, output logic exp_err);
    int   n;
    int   badr;
    logic legal;
    n = 1 << siz;
    legal = (siz <= 2) && (adr % n == 0);
    exp_rdt = '0;
    exp_err = !legal;
    if (legal) begin
      for (int k = 0; k < n; k++) begin
        // value byte k, from the low address or from the top byte
        badr = (ndn == tcb_pkg::TCB_BIG) ? adr + n - 1 - k : adr + k;
        if (wen) model[badr] = wdt[8*k +: 8];
        else exp_rdt[8*k +: 8] = model[badr];
      end
    end
  endtask

  // everything is stable half a cycle after the edge
  always @(negedge clk) begin: monitor
    logic [31:0] e_rdt;
    logic        e_err;
    if (reset) begin
      exp_rdt_q.delete();
      exp_err_q.delete();
    end
    // ready only once every word has been cleared
    compare_value("rdy", 32'(run_cnt >= `TCB_MEM_WORDS), 32'(rdy));
    // one response for each transfer one cycle back, none otherwise
    compare_value("rsp_vld", 32'(exp_rdt_q.size() > 0), 32'(rsp_vld));
    if (exp_rdt_q.size() > 0) begin
      e_rdt = exp_rdt_q.pop_front();
      e_err = exp_err_q.pop_front();
      if (rsp_vld === 1'b1) begin
        compare_value("err", 32'(e_err), 32'(err));
        compare_value("rdt", e_rdt, rdt);
      end
    end else begin
      compare_value("err", 32'd0, 32'(err));
    end
    // request on the lines now transfers at the next edge
    if (!reset && vld === 1'b1 && rdy === 1'b1) begin
      predict(e_rdt, e_err);
      exp_rdt_q.push_back(e_rdt);
      exp_err_q.push_back(e_err);
    end
  end: monitor

endmodule: tcb_checker

`default_nettype wire

/* bench/tcb_tb.sv */
/* testbench top, clock, reset, LCG stimulus,
   watchdog, DUT and checker instances */

`default_nettype none

`include "tcb_consts.svh"

module tcb_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 20;
  localparam int RST_CYC    = 5;
  localparam int N_RAND     = 600;
  // reset, clear, two sweeps, directed accesses, random run, margin
  localparam int WDOG_CYC   = RST_CYC + 3 * `TCB_MEM_WORDS + 16 + N_RAND + 100;

  logic              clk = 1'b0;
  logic              reset;
  logic              vld;
  logic              wen;
  tcb_pkg::tcb_adr_t adr;
  tcb_pkg::tcb_siz_t siz;
  tcb_pkg::tcb_ndn_t ndn;
  tcb_pkg::tcb_dat_t wdt;
  logic              rdy;
  logic              rsp_vld;
  tcb_pkg::tcb_dat_t rdt;
  logic              err;

  // totals from the checker
  int chk_cnt;
  int err_cnt;

  // LCG state
  logic [31:0] seed;

  always #(CLK_PERIOD / 2) clk = ~clk;

  tcb_endian_sys dut_i (
    .clk (clk), .reset (reset), .vld (vld), .wen (wen), .adr (adr), .siz (siz),
    .ndn (ndn), .wdt (wdt), .rdy (rdy), .rsp_vld (rsp_vld), .rdt (rdt), .err (err)
  );

  tcb_checker chk_i (
    .clk (clk), .reset (reset), .vld (vld), .wen (wen), .adr (adr), .siz (siz),
    .ndn (ndn), .wdt (wdt), .rdy (rdy), .rsp_vld (rsp_vld), .rdt (rdt), .err (err),
    .chk_cnt (chk_cnt), .err_cnt (err_cnt)
  );

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // upper half only, low LCG bits repeat too soon
  task automatic draw_bits(output logic [15:0] v);
    seed = lcg_step(seed);
    v = seed[31:16];
  endtask

  // one request cycle, driven just after the edge
  task automatic send(input logic v, input logic w, input tcb_pkg::tcb_adr_t a,
                      input tcb_pkg::tcb_siz_t s, input tcb_pkg::tcb_ndn_t n,
                      input tcb_pkg::tcb_dat_t d);
    @(posedge clk);
    #2;
    vld = v;
    wen = w;
    adr = a;
    siz = s;
    ndn = n;
    wdt = d;
  endtask

  task automatic random_access();
    logic [15:0]       ctl;
    logic [15:0]       hi;
    logic [15:0]       lo;
    tcb_pkg::tcb_adr_t a;
    tcb_pkg::tcb_siz_t s;
    draw_bits(ctl);
    draw_bits(hi);
    draw_bits(lo);
    s = ctl[13:12];
    a = ctl[7:0];
    // half the accesses pushed onto an aligned address
    if (ctl[11]) a = a & ~tcb_pkg::tcb_adr_t'((1 << s) - 1);
    // vld about three cycles in four
    send(ctl[15:14] != 2'b00, ctl[10], a, s,
         ctl[9] ? tcb_pkg::TCB_BIG : tcb_pkg::TCB_LITTLE, {hi, lo});
  endtask

  // word reads of the whole memory
  task automatic sweep_words();
    for (int i = 0; i < `TCB_MEM_WORDS; i++) begin
      send(1'b1, 1'b0, tcb_pkg::tcb_adr_t'(4 * i), 2'd2, tcb_pkg::TCB_LITTLE, '0);
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin: stimulus
    reset = 1'b1;
    vld   = 1'b0;
    wen   = 1'b0;
    adr   = '0;
    siz   = '0;
    ndn   = tcb_pkg::TCB_LITTLE;
    wdt   = '0;
    seed  = 32'd89149;
    repeat (RST_CYC) @(posedge clk);
    #2;
    reset = 1'b0;
    // memory clear in progress
    while (rdy !== 1'b1) begin
      @(posedge clk);
      #2;
    end
    sweep_words();
    // partial writes into one word pair, LE and BE
    send(1'b1, 1'b1, 8'h10, 2'd2, tcb_pkg::TCB_LITTLE, 32'hA1B2C3D4);
    send(1'b1, 1'b1, 8'h12, 2'd0, tcb_pkg::TCB_LITTLE, 32'h0000005E);
    send(1'b1, 1'b1, 8'h16, 2'd1, tcb_pkg::TCB_BIG, 32'h0000BEEF);
    // misaligned and oversize, word must stay as it is
    send(1'b1, 1'b1, 8'h11, 2'd2, tcb_pkg::TCB_LITTLE, 32'hFFFFFFFF);
    send(1'b1, 1'b1, 8'h14, 2'd3, tcb_pkg::TCB_LITTLE, 32'hFFFFFFFF);
    send(1'b1, 1'b0, 8'h10, 2'd2, tcb_pkg::TCB_LITTLE, '0);
    send(1'b1, 1'b0, 8'h14, 2'd2, tcb_pkg::TCB_BIG, '0);
    send(1'b1, 1'b0, 8'h10, 2'd1, tcb_pkg::TCB_BIG, '0);
    send(1'b1, 1'b0, 8'h13, 2'd1, tcb_pkg::TCB_LITTLE, '0);
    repeat (N_RAND) random_access();
    sweep_words();
    send(1'b0, 1'b0, '0, '0, tcb_pkg::TCB_LITTLE, '0);
    // let the last response drain
    repeat (3) @(posedge clk);
    $display("%0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end: stimulus

  initial begin: watchdog
    #(WDOG_CYC * CLK_PERIOD);
    $display("timeout, run still going after %0d cycles", WDOG_CYC);
    $display("TEST FAILED");
    $finish;
  end: watchdog

endmodule: tcb_tb

`default_nettype wire

/* common/tcb_consts.svh */
/* bus widths, memory depth and response delay
   constants for the TCB subsystem */

`ifndef TCB_CONSTS_SVH
`define TCB_CONSTS_SVH

// byte address width
`define TCB_ABW 8

// data bus width and number of byte lanes
`define TCB_DBW 32
`define TCB_BEW 4

// on-chip memory depth in words
`define TCB_MEM_WORDS 64

// response delay in cycles, fixed at one
`define TCB_DLY 1

`endif

/* common/tcb_pkg.sv */
/* TCB vector types and the enums for endianness
   and the control state machine */

`default_nettype none

`include "tcb_consts.svh"

package tcb_pkg;

  //////////////////////////////////////////////////
  // bus vectors
  //////////////////////////////////////////////////

  // byte address
  typedef logic [`TCB_ABW-1:0] tcb_adr_t;

  // data word and byte enables
  typedef logic [`TCB_DBW-1:0] tcb_dat_t;
  typedef logic [`TCB_BEW-1:0] tcb_ben_t;

  // log2 of the transfer size in bytes
  typedef logic [1:0] tcb_siz_t;

  // byte lane index within a word
  typedef logic [$clog2(`TCB_BEW)-1:0] tcb_lane_t;

  // word address into the memory
  typedef logic [$clog2(`TCB_MEM_WORDS)-1:0] tcb_mem_adr_t;

  //////////////////////////////////////////////////
  // enums
  //////////////////////////////////////////////////

  // value byte order in reference mode
  typedef enum logic {
    TCB_LITTLE = 1'b0,
    TCB_BIG    = 1'b1
  } tcb_ndn_t;

  // control FSM, memory clear then normal service
  typedef enum logic {
    CTRL_CLEAR = 1'b0,
    CTRL_RUN   = 1'b1
  } tcb_ctrl_state_t;

endpackage: tcb_pkg

`default_nettype wire

/* hdl/tcb_ctrl.sv */
/* control FSM, memory clear, handshake,
   response pipeline and error generation */

`default_nettype none

`include "tcb_consts.svh"

module tcb_ctrl (
  input  logic               clk,
  input  logic               reset,
  // manager request
  input  logic               vld,
  input  logic               wen,
  input  tcb_pkg::tcb_adr_t  adr,
  input  tcb_pkg::tcb_siz_t  siz,
  input  tcb_pkg::tcb_ndn_t  ndn,
  // from the lane map
  input  tcb_pkg::tcb_lane_t lane,
  input  logic               mal,
  // handshake back to the manager
  output logic               rdy,
  // memory control
  output logic               mem_en,
  output logic               mem_we,
  output tcb_pkg::tcb_mem_adr_t mem_adr,
  output logic               mem_clr,
  // response stage
  output logic               rsp_vld,
  output logic               rsp_err,
  output logic               rsp_wen,
  output tcb_pkg::tcb_siz_t  rsp_siz,
  output tcb_pkg::tcb_ndn_t  rsp_ndn,
  output tcb_pkg::tcb_lane_t rsp_lane
);

  tcb_pkg::tcb_ctrl_state_t state;
  tcb_pkg::tcb_ctrl_state_t state_nxt;

  // word being cleared
  tcb_pkg::tcb_mem_adr_t clr_cnt;
  logic                  clr_last;

  // request accepted this cycle
  logic trn;

  //////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////

  assign clr_last = clr_cnt == tcb_pkg::tcb_mem_adr_t'(`TCB_MEM_WORDS - 1);

  always_comb begin
    state_nxt = state;
    case (state)
      tcb_pkg::CTRL_CLEAR: if (clr_last) state_nxt = tcb_pkg::CTRL_RUN;
      default:             state_nxt = tcb_pkg::CTRL_RUN;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= tcb_pkg::CTRL_CLEAR;
      clr_cnt <= '0;
    end else begin
      state <= state_nxt;
      // one word per cycle while clearing
      if (state == tcb_pkg::CTRL_CLEAR) clr_cnt <= clr_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // handshake and memory access
  //////////////////////////////////////////////////

  assign rdy = state == tcb_pkg::CTRL_RUN;
  assign trn = vld && rdy;

  // clear owns the memory until the run state
  assign mem_clr = state == tcb_pkg::CTRL_CLEAR;
  assign mem_en  = trn;
  // illegal writes never reach memory
  assign mem_we  = trn && wen && !mal;
  assign mem_adr = mem_clr ? clr_cnt : adr[`TCB_ABW-1:$clog2(`TCB_BEW)];

  //////////////////////////////////////////////////
  // response stage
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      rsp_vld <= 1'b0;
      rsp_err <= 1'b0;
    end else begin
      rsp_vld <= trn;
      rsp_err <= trn && mal;
    end
  end

  // access details for the read aligner
  always_ff @(posedge clk) begin
    if (trn) begin
      rsp_wen  <= wen;
      rsp_siz  <= siz;
      rsp_ndn  <= ndn;
      rsp_lane <= lane;
    end
  end

  // no handshake before the last word has been cleared
  assert property (@(posedge clk) disable iff (reset)
    $rose(rdy) |-> $past(clr_last));

  // access answered with an error left the memory untouched
  assert property (@(posedge clk) disable iff (reset)
    rsp_err |-> !$past(mem_we, `TCB_DLY));

endmodule: tcb_ctrl

`default_nettype wire

/* hdl/tcb_endian_sys.sv */
/* TCB subsystem top, lane map, control,
   memory and read aligner */

`default_nettype none

module tcb_endian_sys (
  input  logic              clk,
  input  logic              reset,
  // request, reference mode
  input  logic              vld,
  input  logic              wen,
  input  tcb_pkg::tcb_adr_t adr,
  input  tcb_pkg::tcb_siz_t siz,
  input  tcb_pkg::tcb_ndn_t ndn,
  input  tcb_pkg::tcb_dat_t wdt,
  // handshake and response
  output logic              rdy,
  output logic              rsp_vld,
  output tcb_pkg::tcb_dat_t rdt,
  output logic              err
);

  // lane map to memory and control
  tcb_pkg::tcb_ben_t     mem_ben;
  tcb_pkg::tcb_dat_t     mem_wdt;
  tcb_pkg::tcb_lane_t    lane;
  logic                  mal;

  // memory control
  logic                  mem_en;
  logic                  mem_we;
  logic                  mem_clr;
  tcb_pkg::tcb_mem_adr_t mem_adr;
  tcb_pkg::tcb_dat_t     mem_rdt;

  // response stage
  logic                  rsp_wen;
  tcb_pkg::tcb_siz_t     rsp_siz;
  tcb_pkg::tcb_ndn_t     rsp_ndn;
  tcb_pkg::tcb_lane_t    rsp_lane;

  //////////////////////////////////////////////////
  // request path
  //////////////////////////////////////////////////

  tcb_lane_map u_lane_map (
    .adr     (adr),
    .siz     (siz),
    .ndn     (ndn),
    .wdt     (wdt),
    .mem_ben (mem_ben),
    .mem_wdt (mem_wdt),
    .lane    (lane),
    .mal     (mal)
  );

  tcb_ctrl u_ctrl (
    .clk      (clk),
    .reset    (reset),
    .vld      (vld),
    .wen      (wen),
    .adr      (adr),
    .siz      (siz),
    .ndn      (ndn),
    .lane     (lane),
    .mal      (mal),
    .rdy      (rdy),
    .mem_en   (mem_en),
    .mem_we   (mem_we),
    .mem_adr  (mem_adr),
    .mem_clr  (mem_clr),
    .rsp_vld  (rsp_vld),
    .rsp_err  (err),
    .rsp_wen  (rsp_wen),
    .rsp_siz  (rsp_siz),
    .rsp_ndn  (rsp_ndn),
    .rsp_lane (rsp_lane)
  );

  tcb_mem u_mem (
    .clk (clk),
    .en  (mem_en),
    .we  (mem_we),
    .clr (mem_clr),
    .adr (mem_adr),
    .ben (mem_ben),
    .wdt (mem_wdt),
    .rdt (mem_rdt)
  );

  //////////////////////////////////////////////////
  // response path
  //////////////////////////////////////////////////

  tcb_read_align u_read_align (
    .mem_rdt (mem_rdt),
    .lane    (rsp_lane),
    .siz     (rsp_siz),
    .ndn     (rsp_ndn),
    .err     (err),
    .wen     (rsp_wen),
    .rdt     (rdt)
  );

endmodule: tcb_endian_sys

`default_nettype wire

/* hdl/tcb_mem.sv */
/* byte-enabled word memory, registered read
   and whole word clear */

`default_nettype none

`include "tcb_consts.svh"

module tcb_mem (
  input  logic                  clk,
  // access control
  input  logic                  en,
  input  logic                  we,
  input  logic                  clr,
  // address, lanes and write data
  input  tcb_pkg::tcb_mem_adr_t adr,
  input  tcb_pkg::tcb_ben_t     ben,
  input  tcb_pkg::tcb_dat_t     wdt,
  // read data, one cycle after en
  output tcb_pkg::tcb_dat_t     rdt
);

  // byte width of one lane
  localparam int BYW = `TCB_DBW / `TCB_BEW;

  // storage, one entry per word, bytes addressable
  logic [`TCB_BEW-1:0][BYW-1:0] mem [`TCB_MEM_WORDS];

  // write word as bytes
  logic [`TCB_BEW-1:0][BYW-1:0] wdt_b;

  assign wdt_b = wdt;

  //////////////////////////////////////////////////
  // write port
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (clr) begin
      // clear wins over a normal write
      mem[adr] <= '0;
    end else if (en && we) begin
      for (int b = 0; b < `TCB_BEW; b++) begin
        if (ben[b]) mem[adr][b] <= wdt_b[b];
      end
    end
  end

  //////////////////////////////////////////////////
  // read port
  //////////////////////////////////////////////////

  // read also on writes, aligner drops it
  always_ff @(posedge clk) begin
    if (en) rdt <= mem[adr];
  end

endmodule: tcb_mem

`default_nettype wire

/* tcb_bridge/tcb_lane_map.sv */
/* reference to memory mode request converter,
   with misalignment and oversize detection */

`default_nettype none

`include "tcb_consts.svh"

module tcb_lane_map (
  // request from the manager, reference mode
  input  tcb_pkg::tcb_adr_t  adr,
  input  tcb_pkg::tcb_siz_t  siz,
  input  tcb_pkg::tcb_ndn_t  ndn,
  input  tcb_pkg::tcb_dat_t  wdt,
  // request towards memory, memory mode
  output tcb_pkg::tcb_ben_t  mem_ben,
  output tcb_pkg::tcb_dat_t  mem_wdt,
  output tcb_pkg::tcb_lane_t lane,
  // illegal access flag
  output logic               mal
);

  // byte width of one lane
  localparam int BYW = `TCB_DBW / `TCB_BEW;

  //////////////////////////////////////////////////
  // size decode and alignment
  //////////////////////////////////////////////////

  // number of bytes in the transfer, 8 for siz 3
  logic [3:0] num;

  assign num = 4'd1 << siz;

  // first lane touched is the low address bits
  assign lane = adr[$clog2(`TCB_BEW)-1:0];

  always_comb begin
    // size must be known before the check below means anything
    assert #0 (!$isunknown(siz))
      else $error("siz unknown while checking alignment");
    case (siz)
      2'd0:    mal = 1'b0;
      2'd1:    mal = adr[0];
      2'd2:    mal = |adr[1:0];
      // wider than the 32-bit bus
      default: mal = 1'b1;
    endcase
  end

  //////////////////////////////////////////////////
  // write lane steering
  //////////////////////////////////////////////////

  // write data split into bytes
  logic [`TCB_BEW-1:0][BYW-1:0] wdt_b;
  logic [`TCB_BEW-1:0][BYW-1:0] mem_wdt_b;

  // which value byte feeds each memory lane
  tcb_pkg::tcb_lane_t sel [`TCB_BEW];

  // lane is covered by the transfer
  logic [`TCB_BEW-1:0] hit;

  assign wdt_b = wdt;

  for (genvar i = 0; i < `TCB_BEW; i++) begin: g_lane
    // distance of this lane from the first lane
    tcb_pkg::tcb_lane_t ofs;

    assign ofs = tcb_pkg::tcb_lane_t'(i) - lane;

    // only lanes below the byte count take part
    assign hit[i] = {2'b00, ofs} < num;

    // little endian counts up, big endian counts down from the top byte
    assign sel[i] = (ndn == tcb_pkg::TCB_BIG) ?
                    tcb_pkg::tcb_lane_t'(num - 4'd1 - {2'b00, ofs}) : ofs;

    // steer the byte, unused lanes carry zero
    assign mem_wdt_b[i] = hit[i] ? wdt_b[sel[i]] : '0;
    assign mem_ben[i]   = hit[i];
  end: g_lane

  assign mem_wdt = mem_wdt_b;

endmodule: tcb_lane_map

`default_nettype wire

/* tcb_bridge/tcb_read_align.sv */
/* response converter, memory read lanes back
   to a reference mode value */

`default_nettype none

`include "tcb_consts.svh"

module tcb_read_align (
  // registered memory word
  input  tcb_pkg::tcb_dat_t  mem_rdt,
  // response stage from the controller
  input  tcb_pkg::tcb_lane_t lane,
  input  tcb_pkg::tcb_siz_t  siz,
  input  tcb_pkg::tcb_ndn_t  ndn,
  input  logic               err,
  input  logic               wen,
  // read value, reference mode
  output tcb_pkg::tcb_dat_t  rdt
);

  // byte width of one lane
  localparam int BYW = `TCB_DBW / `TCB_BEW;

  // transfer byte count
  logic [3:0] num;

  // memory word and result as byte arrays
  logic [`TCB_BEW-1:0][BYW-1:0] mem_rdt_b;
  logic [`TCB_BEW-1:0][BYW-1:0] rdt_b;

  // only reads without error return data
  logic rd_ok;

  assign num       = 4'd1 << siz;
  assign mem_rdt_b = mem_rdt;
  assign rd_ok     = !err && !wen;

  //////////////////////////////////////////////////
  // inverse lane map
  //////////////////////////////////////////////////

  for (genvar k = 0; k < `TCB_BEW; k++) begin: g_byte
    // lane that holds value byte k
    tcb_pkg::tcb_lane_t src;

    // value byte is within the transfer size
    logic in_siz;

    assign in_siz = 4'(k) < num;

    // little endian, lane + k; big endian, mirror within the size
    assign src = (ndn == tcb_pkg::TCB_BIG) ?
                 tcb_pkg::tcb_lane_t'({2'b00, lane} + num - 4'd1 - 4'(k)) :
                 tcb_pkg::tcb_lane_t'(lane + tcb_pkg::tcb_lane_t'(k));

    // bytes above the size read as zero
    assign rdt_b[k] = (rd_ok && in_siz) ? mem_rdt_b[src] : '0;
  end: g_byte

  assign rdt = rdt_b;

endmodule: tcb_read_align

`default_nettype wire

/* verilog.f */
+incdir+common
common/tcb_pkg.sv
tcb_bridge/tcb_lane_map.sv
tcb_bridge/tcb_read_align.sv
hdl/tcb_ctrl.sv
hdl/tcb_mem.sv
hdl/tcb_endian_sys.sv
bench/tcb_checker.sv
bench/tcb_tb.sv
